//--- hw/rf_pkg.sv
// Register file shared definitions
`default_nettype none

package rf_pkg;

  // ------------------------------------------------------------
  // default geometry of the register file macro
  // ------------------------------------------------------------

  // width of one storage word in bits
  localparam int DEF_DATA_WIDTH = 16;

  // number of storage words, which has to be a power of two
  localparam int DEF_DEPTH = 16;

  // number of observed control bits folded into one observation flop
  localparam int DEF_OBS_XOR_SIZE = 3;

  // each write mask bit covers this many data bits
  localparam int BYTE_BITS = 8;

  // ------------------------------------------------------------
  // observation bank sizing
  // ------------------------------------------------------------

  // one flop per group of xor_size bits, and a partial last group
  // still gets a flop of its own
  function automatic int obs_flop_num(input int pin_num, input int xor_size);
    return (pin_num + xor_size - 1) / xor_size;
  endfunction

endpackage

`default_nettype wire

//--- hw/rf_wr_if.sv
// Register file write request
`timescale 1ns/1ps
`default_nettype none

interface rf_wr_if #(
  parameter int DATA_WIDTH = rf_pkg::DEF_DATA_WIDTH,
  parameter int DEPTH      = rf_pkg::DEF_DEPTH
) ();

  import rf_pkg::*;

  localparam int ADDR_WIDTH = $clog2(DEPTH);
  localparam int BYTE_NUM   = DATA_WIDTH / BYTE_BITS;

  // strobe that is high for exactly one cycle per accepted write
  logic                  we;
  // target word of the write
  logic [ADDR_WIDTH-1:0] waddr;
  // write data, only the enabled bytes land in the array
  logic [DATA_WIDTH-1:0] wdata;
  // one enable bit per byte of wdata
  logic [BYTE_NUM-1:0]   wmask;

  // the write stage launches the request
  modport producer (output we, waddr, wdata, wmask);

  // the storage array consumes it on the next edge
  modport array (input we, waddr, wdata, wmask);

endinterface

`default_nettype wire

//--- hw/rf_write_stage.sv
// Register file write stage
`timescale 1ns/1ps
`default_nettype none

module rf_write_stage #(
  parameter int DATA_WIDTH  = rf_pkg::DEF_DATA_WIDTH,
  parameter int DEPTH       = rf_pkg::DEF_DEPTH,
  localparam int ADDR_WIDTH = $clog2(DEPTH),
  localparam int BYTE_NUM   = DATA_WIDTH / rf_pkg::BYTE_BITS
) (
  input  logic                  clock_b,
  input  logic                  reset,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic [BYTE_NUM-1:0]   wmask,
  rf_wr_if.producer             wr
);

  // a request only counts as a write when at least one byte is enabled
  logic wr_valid;

  assign wr_valid = we & (|wmask);

  // ------------------------------------------------------------
  // write strobe
  // ------------------------------------------------------------

  // the strobe is the only control bit of the request and it comes up low
  always_ff @(posedge clock_b)
  begin
    if (reset)
    begin
      wr.we <= 1'b0;
    end
    else
    begin
      // empty writes are dropped here and never reach the array
      wr.we <= wr_valid;
    end
  end

  // ------------------------------------------------------------
  // write payload
  // ------------------------------------------------------------

  // address, data and mask follow the inputs every cycle
  // so the observation tap sees the sampled request even when it is dropped
  always_ff @(posedge clock_b)
  begin
    wr.waddr <= waddr;
    wr.wdata <= wdata;
    wr.wmask <= wmask;
  end

endmodule

`default_nettype wire

//--- hw/rf_array.sv
// Register file storage array
`timescale 1ns/1ps
`default_nettype none

module rf_array #(
  parameter int DATA_WIDTH  = rf_pkg::DEF_DATA_WIDTH,
  parameter int DEPTH       = rf_pkg::DEF_DEPTH,
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                  clock_b,
  rf_wr_if.array                wr,
  input  logic [ADDR_WIDTH-1:0] array_raddr,
  output logic [DATA_WIDTH-1:0] array_rdata
);

  import rf_pkg::*;

  localparam int BYTE_NUM = DATA_WIDTH / BYTE_BITS;

  // the storage words themselves
  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // ------------------------------------------------------------
  // write port
  // ------------------------------------------------------------

  // a strobe updates the addressed word one byte lane at a time
  // and lanes with a clear mask bit keep their old contents
  always_ff @(posedge clock_b)
  begin
    if (wr.we)
    begin
      for (int b = 0; b < BYTE_NUM; b++)
      begin
        if (wr.wmask[b])
        begin
          mem[wr.waddr][b*BYTE_BITS +: BYTE_BITS] <= wr.wdata[b*BYTE_BITS +: BYTE_BITS];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------

  // the read is combinational from the registered read address
  // so a word written on one edge is visible right after that edge
  // and the read stage captures it on the following one
  assign array_rdata = mem[array_raddr];

endmodule

`default_nettype wire

//--- hw/rf_read_stage.sv
// Register file read stage
`timescale 1ns/1ps
`default_nettype none

module rf_read_stage #(
  parameter int DATA_WIDTH  = rf_pkg::DEF_DATA_WIDTH,
  parameter int DEPTH       = rf_pkg::DEF_DEPTH,
  localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
  input  logic                  clock_b,
  input  logic                  reset,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic                  array_re,
  output logic [ADDR_WIDTH-1:0] array_raddr,
  input  logic [DATA_WIDTH-1:0] array_rdata,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  rvalid
);

  // ------------------------------------------------------------
  // stage one drives the request into the array
  // ------------------------------------------------------------

  // the read enable is control state and starts out idle
  always_ff @(posedge clock_b)
  begin
    if (reset)
    begin
      array_re <= 1'b0;
    end
    else
    begin
      array_re <= re;
    end
  end

  // the address is taken every cycle
  // so the observation tap tracks the sampled address whether or not re is set
  always_ff @(posedge clock_b)
  begin
    array_raddr <= raddr;
  end

  // ------------------------------------------------------------
  // stage two returns the word
  // ------------------------------------------------------------

  // rvalid pulses for one cycle per read while rdata holds between reads
  // and a new read can enter stage one while the previous one finishes here
  always_ff @(posedge clock_b)
  begin
    if (reset)
    begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end
    else
    begin
      rvalid <= array_re;
      if (array_re)
      begin
        rdata <= array_rdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/rf_obs_compress.sv
// Register file observation flops
`timescale 1ns/1ps
`default_nettype none

module rf_obs_compress #(
  parameter int OBS_PIN_NUM  = 1,
  parameter int OBS_XOR_SIZE = rf_pkg::DEF_OBS_XOR_SIZE,
  parameter int OBS_FLOP_NUM = rf_pkg::obs_flop_num(OBS_PIN_NUM, OBS_XOR_SIZE)
) (
  input  logic                    clock_b,
  input  logic                    reset,
  input  logic [OBS_PIN_NUM-1:0]  obs_in,
  output logic [OBS_FLOP_NUM-1:0] obs
);

  // one parity bit per group of the observed controls
  logic [OBS_FLOP_NUM-1:0] obs_xor;

  // ------------------------------------------------------------
  // fold
  // ------------------------------------------------------------

  // groups start at bit zero and the last one takes whatever is left
  for (genvar g = 0; g < OBS_FLOP_NUM; g++)
  begin : g_group
    if (g < OBS_FLOP_NUM - 1)
    begin : g_full
      assign obs_xor[g] = ^obs_in[g*OBS_XOR_SIZE +: OBS_XOR_SIZE];
    end
    else
    begin : g_tail
      assign obs_xor[g] = ^obs_in[OBS_PIN_NUM-1:g*OBS_XOR_SIZE];
    end
  end

  // ------------------------------------------------------------
  // observation flops
  // ------------------------------------------------------------

  // the array controls are already registered, so one more flop here
  // lines obs up with the read data of the same request
  always_ff @(posedge clock_b)
  begin
    if (reset)
    begin
      obs <= '0;
    end
    else
    begin
      obs <= obs_xor;
    end
  end

endmodule

`default_nettype wire

//--- hw/rf_top.sv
// Register file macro wrapper
`timescale 1ns/1ps
`default_nettype none

module rf_top #(
  parameter int DATA_WIDTH   = rf_pkg::DEF_DATA_WIDTH,
  parameter int DEPTH        = rf_pkg::DEF_DEPTH,
  parameter int OBS_XOR_SIZE = rf_pkg::DEF_OBS_XOR_SIZE,
  localparam int ADDR_WIDTH   = $clog2(DEPTH),
  localparam int BYTE_NUM     = DATA_WIDTH / rf_pkg::BYTE_BITS,
  localparam int OBS_PIN_NUM  = 2 * ADDR_WIDTH + BYTE_NUM + 2,
  localparam int OBS_FLOP_NUM = rf_pkg::obs_flop_num(OBS_PIN_NUM, OBS_XOR_SIZE)
) (
  input  logic                    clock_b,
  input  logic                    reset,
  input  logic                    we,
  input  logic [ADDR_WIDTH-1:0]   waddr,
  input  logic [DATA_WIDTH-1:0]   wdata,
  input  logic [BYTE_NUM-1:0]     wmask,
  input  logic                    re,
  input  logic [ADDR_WIDTH-1:0]   raddr,
  output logic [DATA_WIDTH-1:0]   rdata,
  output logic                    rvalid,
  output logic [OBS_FLOP_NUM-1:0] obs
);

  // ------------------------------------------------------------
  // internal wiring
  // ------------------------------------------------------------

  // registered write request between the write stage and the array
  rf_wr_if #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) wr_if ();

  // registered read request and the word the array returns for it
  logic                   array_re;
  logic [ADDR_WIDTH-1:0]  array_raddr;
  logic [DATA_WIDTH-1:0]  array_rdata;

  // every control and address bit that reaches the array, lsb first
  // we then waddr then wmask then re then raddr
  logic [OBS_PIN_NUM-1:0] obs_vec;

  assign obs_vec = {array_raddr, array_re, wr_if.wmask, wr_if.waddr, wr_if.we};

  // ------------------------------------------------------------
  // producer, buffer and consumer
  // ------------------------------------------------------------

  rf_write_stage #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) rf_write_stage_i (
    .clock_b (clock_b),
    .reset   (reset),
    .we      (we),
    .waddr   (waddr),
    .wdata   (wdata),
    .wmask   (wmask),
    .wr      (wr_if.producer)
  );

  rf_array #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) rf_array_i (
    .clock_b     (clock_b),
    .wr          (wr_if.array),
    .array_raddr (array_raddr),
    .array_rdata (array_rdata)
  );

  rf_read_stage #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) rf_read_stage_i (
    .clock_b     (clock_b),
    .reset       (reset),
    .re          (re),
    .raddr       (raddr),
    .array_re    (array_re),
    .array_raddr (array_raddr),
    .array_rdata (array_rdata),
    .rdata       (rdata),
    .rvalid      (rvalid)
  );

  // ------------------------------------------------------------
  // observation bank on the array controls
  // ------------------------------------------------------------

  rf_obs_compress #(
    .OBS_PIN_NUM  (OBS_PIN_NUM),
    .OBS_XOR_SIZE (OBS_XOR_SIZE),
    .OBS_FLOP_NUM (OBS_FLOP_NUM)
  ) rf_obs_compress_i (
    .clock_b (clock_b),
    .reset   (reset),
    .obs_in  (obs_vec),
    .obs     (obs)
  );

endmodule

`default_nettype wire

//--- test/rf_tb.sv
// Register file testbench
`timescale 1ns/1ps
`default_nettype none

module rf_tb;

  localparam int DATA_WIDTH = 16;
  localparam int DEPTH      = 16;
  localparam int ADDR_WIDTH = 4;
  localparam int BYTE_NUM   = 2;
  localparam int OBS_BITS   = 12;
  localparam int OBS_GROUP  = 3;
  localparam int OBS_FLOPS  = 4;
  localparam int HIST       = 512;
  localparam int TIMEOUT    = 16;

  // table operations, bit 0 writes and bit 1 reads
  localparam bit [1:0] OP_IDLE = 2'd0;
  localparam bit [1:0] OP_WR   = 2'd1;
  localparam bit [1:0] OP_RD   = 2'd2;
  localparam bit [1:0] OP_BOTH = 2'd3;

  logic                  clock_b;
  logic                  reset;
  logic                  we;
  logic [ADDR_WIDTH-1:0] waddr;
  logic [DATA_WIDTH-1:0] wdata;
  logic [BYTE_NUM-1:0]   wmask;
  logic                  re;
  logic [ADDR_WIDTH-1:0] raddr;
  logic [DATA_WIDTH-1:0] rdata;
  logic                  rvalid;
  logic [OBS_FLOPS-1:0]  obs;

  rf_top #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH), .OBS_XOR_SIZE(OBS_GROUP)) rf_top_i (
    .clock_b (clock_b),
    .reset   (reset),
    .we      (we),
    .waddr   (waddr),
    .wdata   (wdata),
    .wmask   (wmask),
    .re      (re),
    .raddr   (raddr),
    .rdata   (rdata),
    .rvalid  (rvalid),
    .obs     (obs)
  );

  // ------------------------------------------------------------
  // reference model state
  // ------------------------------------------------------------

  // array model, updated in the cycle a write is driven but after that cycle's read
  logic [DATA_WIDTH-1:0] model_mem [DEPTH];
  // value rdata should hold between reads
  logic [DATA_WIDTH-1:0] hold_data;
  // expected outputs indexed by the cycle in which they show up
  bit                    exp_valid [HIST];
  logic [DATA_WIDTH-1:0] exp_data [HIST];
  logic [OBS_FLOPS-1:0]  exp_obs [HIST];
  string                 rd_name [HIST];
  string                 obs_name [HIST];
  int                    cyc;
  int                    outstanding;

  // stimulus table, one row per cycle
  string                 tbl_name [$];
  bit [1:0]              tbl_op [$];
  logic [ADDR_WIDTH-1:0] tbl_addr [$];
  logic [DATA_WIDTH-1:0] tbl_data [$];
  logic [BYTE_NUM-1:0]   tbl_mask [$];
  logic [DATA_WIDTH-1:0] tbl_exp [$];

  initial
  begin
    clock_b = 1'b0;
    forever
    begin
      #50 clock_b = ~clock_b;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  // grouped xor of the control vector, lsb first we, waddr, wmask, re, raddr
  function automatic logic [OBS_FLOPS-1:0] obs_expect(input bit w,
      input logic [ADDR_WIDTH-1:0] wa, input logic [BYTE_NUM-1:0] wm, input bit r,
      input logic [ADDR_WIDTH-1:0] ra);
    logic [OBS_BITS-1:0]  vec;
    logic [OBS_FLOPS-1:0] res;
    // a write with no byte enabled shows up with its strobe low
    vec = {ra, r, wm, wa, w & (|wm)};
    res = '0;
    for (int i = 0; i < OBS_BITS; i++)
    begin
      res[i / OBS_GROUP] = res[i / OBS_GROUP] ^ vec[i];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %s expected %h actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input string name, input bit [1:0] op,
      input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
      input logic [BYTE_NUM-1:0] mask, input logic [DATA_WIDTH-1:0] rd_exp);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_data.push_back(data);
    tbl_mask.push_back(mask);
    tbl_exp.push_back(rd_exp);
  endtask

  // drives one request on the rising edge and checks all outputs at the falling edge
  task automatic run_cycle(input string name, input bit [1:0] op,
      input logic [ADDR_WIDTH-1:0] wa, input logic [ADDR_WIDTH-1:0] ra,
      input logic [DATA_WIDTH-1:0] wd, input logic [BYTE_NUM-1:0] wm,
      input logic [DATA_WIDTH-1:0] rd_exp);
    @(posedge clock_b);
    we    <= op[0];
    waddr <= wa;
    wdata <= wd;
    wmask <= wm;
    re    <= op[1];
    raddr <= ra;
    // read data and obs for this request both come back two edges later
    exp_obs[cyc + 2]  = obs_expect(op[0], wa, wm, op[1], ra);
    obs_name[cyc + 2] = name;
    if (op[1])
    begin
      exp_valid[cyc + 2] = 1'b1;
      exp_data[cyc + 2]  = rd_exp;
      rd_name[cyc + 2]   = name;
      outstanding++;
    end
    // a same cycle read already took the old word, so the write lands afterwards
    if (op[0])
    begin
      for (int b = 0; b < BYTE_NUM; b++)
      begin
        if (wm[b])
          model_mem[wa][b*8 +: 8] = wd[b*8 +: 8];
      end
    end
    @(negedge clock_b);
    if (exp_valid[cyc])
    begin
      hold_data = exp_data[cyc];
      outstanding--;
    end
    check_value({(exp_valid[cyc] ? rd_name[cyc] : name), " rvalid"}, exp_valid[cyc], rvalid);
    check_value({rd_name[cyc], " rdata"}, hold_data, rdata);
    check_value({obs_name[cyc], " obs"}, exp_obs[cyc], obs);
    cyc++;
  endtask

  // idles until every read has come back, bounded by a timeout
  task automatic drain_reads(input string name);
    int waited;
    waited = 0;
    while (outstanding != 0)
    begin
      if (waited == TIMEOUT)
      begin
        $display("timed out waiting for rvalid with %0d reads pending", outstanding);
        $display("Finished with errors");
        $fatal(1, "rvalid timeout");
      end
      run_cycle(name, OP_IDLE, '0, '0, '0, '0, '0);
      waited++;
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial
  begin
    logic [31:0]           r;
    logic [ADDR_WIDTH-1:0] ra;
    reset = 1'b1;
    we    = 1'b0;
    waddr = '0;
    wdata = '0;
    wmask = '0;
    re    = 1'b0;
    raddr = '0;
    cyc = 0;
    outstanding = 0;
    hold_data = '0;
    void'($urandom(32'ha0579292));
    for (int i = 0; i < HIST; i++)
    begin
      exp_valid[i] = 1'b0;
      exp_obs[i]   = '0;
      rd_name[i]   = "reset";
      obs_name[i]  = "reset";
    end
    // name, op, address, data, mask, expected read word
    add_row("full write a3", OP_WR, 4'd3, 16'hbeef, 2'b11, '0);
    add_row("gap", OP_IDLE, 4'd0, 16'h0000, 2'b00, '0);
    add_row("read a3", OP_RD, 4'd3, 16'h0000, 2'b00, 16'hbeef);
    add_row("full write a5", OP_WR, 4'd5, 16'h1234, 2'b11, '0);
    add_row("read a5 next cycle", OP_RD, 4'd5, 16'h0000, 2'b00, 16'h1234);
    add_row("low byte a3", OP_WR, 4'd3, 16'h00aa, 2'b01, '0);
    add_row("zero mask a3", OP_WR, 4'd3, 16'h5555, 2'b00, '0);
    add_row("high byte a5", OP_WR, 4'd5, 16'h7700, 2'b10, '0);
    add_row("read a3 bytes", OP_RD, 4'd3, 16'h0000, 2'b00, 16'hbeaa);
    add_row("read a5 bytes", OP_RD, 4'd5, 16'h0000, 2'b00, 16'h7734);
    add_row("full write a9", OP_WR, 4'd9, 16'hcafe, 2'b11, '0);
    add_row("read a3 again", OP_RD, 4'd3, 16'h0000, 2'b00, 16'hbeaa);
    add_row("both a9 old word", OP_BOTH, 4'd9, 16'h0001, 2'b01, 16'hcafe);
    add_row("read a9 new word", OP_RD, 4'd9, 16'h0000, 2'b00, 16'hca01);
    add_row("read a5 last", OP_RD, 4'd5, 16'h0000, 2'b00, 16'h7734);
    add_row("tail", OP_IDLE, 4'd0, 16'h0000, 2'b00, '0);

    repeat (8) @(posedge clock_b);
    reset <= 1'b0;
    @(negedge clock_b);
    check_value("reset rvalid", 32'd0, rvalid);
    check_value("reset rdata", 32'd0, rdata);
    check_value("reset obs", 32'd0, obs);

    foreach (tbl_name[i])
    begin
      run_cycle(tbl_name[i], tbl_op[i], tbl_addr[i], tbl_addr[i], tbl_data[i], tbl_mask[i],
        tbl_exp[i]);
    end
    drain_reads("directed drain");

    // fill every word so random reads never see uninitialized storage
    for (int a = 0; a < DEPTH; a++)
    begin
      r = $urandom;
      run_cycle("fill", OP_WR, ADDR_WIDTH'(a), '0, r[15:0], 2'b11, '0);
    end

    for (int i = 0; i < 200; i++)
    begin
      r  = $urandom;
      ra = r[9:6];
      // concurrent writes and reads go to differing words
      if (r[1:0] == OP_BOTH && ra == r[5:2])
        ra = ra + 1'b1;
      run_cycle($sformatf("random %0d", i), r[1:0], r[5:2], ra, r[31:16], r[11:10],
        model_mem[ra]);
    end
    drain_reads("random drain");
    repeat (3) run_cycle("flush", OP_IDLE, '0, '0, '0, '0, '0);

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/rf_pkg.sv
hw/rf_wr_if.sv
hw/rf_write_stage.sv
hw/rf_array.sv
hw/rf_read_stage.sv
hw/rf_obs_compress.sv
hw/rf_top.sv
test/rf_tb.sv
